/* dmm_settings.svh */
/*
  Shared settings of the multimeter control FPGA.
  SPI frame geometry, register map, mode codes and conditioning word width.
*/

`ifndef DMM_SETTINGS_SVH
`define DMM_SETTINGS_SVH

//////////////////////////////////////////////////
// spi frame

// address byte, MSB is the write flag
`define SPI_ADDR_BITS   8
// data word that follows the address byte
`define SPI_DATA_BITS   32
// cs_n low, then exactly this many sck bits
`define SPI_FRAME_BITS  40

//////////////////////////////////////////////////
// register indexes, low two bits of the address

`define REG_LED         2'd0
`define REG_MODE        2'd1
`define REG_DIRECT      2'd2
`define REG_SAMPLE_DUR  2'd3

//////////////////////////////////////////////////
// mode register, low three bits
// codes 5 to 7 drive all zeros

`define MODE_IDLE       3'd0
`define MODE_ONES       3'd1
`define MODE_PATTERN    3'd2
`define MODE_DIRECT     3'd3
`define MODE_AZ         3'd4

// conditioning output word
`define COND_BITS       29

// az mux code that routes the hi input
`define AZMUX_HI_VAL    4'b1000

`endif

/* cond_pkg.sv */
/*
  Conditioning word types.
  The 29-bit output word is used either as raw bits or by field.
*/

`include "dmm_settings.svh"

`default_nettype none

package cond_pkg;

  // one analog mux control
  // enable on top, select in the low three bits
  typedef struct packed {
    logic       en;
    logic [2:0] sel;
  } mux4_t;

  //////////////////////////////////////////////////
  // field view of the output word, MSB first

  typedef struct packed {
    // single control lines, bits 28 down to 26
    logic       spi_interrupt;
    logic       meas_complete;
    logic       cmpr_latch;
    // adc current switches
    logic [3:0] adcmux;
    // monitor pins for the scope
    logic [7:0] monitor;
    logic       led0;
    // pre-charge switch
    logic       sig_pc_sw;
    // input muxes, azmux sits at bit 0
    mux4_t      himux2;
    mux4_t      himux;
    mux4_t      azmux;
  } cond_fields_t;

  // pattern, ones and direct modes treat the word as raw bits
  // idle and az modes fill it by field
  typedef union packed {
    logic [`COND_BITS-1:0] raw;
    cond_fields_t          fields;
  } cond_word_u;

endpackage

`default_nettype wire

/* spi_reg_pkg.sv */
/*
  SPI register access types.
  Address byte layout, the write request and the register file.
*/

`include "dmm_settings.svh"

`default_nettype none

package spi_reg_pkg;

  // address byte as it arrives on mosi
  typedef struct packed {
    logic       write;
    // not decoded
    logic [4:0] reserved;
    logic [1:0] index;
  } reg_addr_t;

  //////////////////////////////////////////////////
  // access from the slave to the register bank

  // valid pulses one clk at the end of a complete frame
  // index is also held between frames for the read mux
  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic [1:0]                index;
    logic [`SPI_DATA_BITS-1:0] wdata;
  } reg_req_t;

  // the four mcu registers
  typedef struct packed {
    logic [`SPI_DATA_BITS-1:0] led;
    logic [`SPI_DATA_BITS-1:0] mode;
    logic [`SPI_DATA_BITS-1:0] direct;
    logic [`SPI_DATA_BITS-1:0] sample_dur;
  } reg_file_t;

endpackage

`default_nettype wire

/* spi_slave.sv */
/*
  SPI mode 0 slave running on the system clock.
  Oversamples the pins, shifts 40-bit frames and issues register accesses.
*/

`timescale 1ns/100ps

`include "dmm_settings.svh"

`default_nettype none

module spi_slave
  import spi_reg_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sck,
  input  logic                      cs_n,
  input  logic                      mosi,
  input  logic [`SPI_DATA_BITS-1:0] rdata,
  output logic                      miso,
  output reg_req_t                  req
);

  localparam int unsigned CNT_W = 6;
  localparam logic [CNT_W-1:0] ADDR_LEN = CNT_W'(`SPI_ADDR_BITS);
  localparam logic [CNT_W-1:0] FRAME_LEN = CNT_W'(`SPI_FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_MAX = '1;

  logic [2:0]                 sck_sync;
  logic [2:0]                 cs_sync;
  logic [1:0]                 mosi_sync;
  logic                       sck_rise;
  logic                       sck_fall;
  logic                       cs_rise;
  logic                       cs_active;
  logic [CNT_W-1:0]           bit_cnt;
  logic [`SPI_FRAME_BITS-1:0] rx_shift;
  logic [`SPI_DATA_BITS-1:0]  tx_shift;
  reg_addr_t                  addr_q;
  logic                       load_pend;
  logic                       valid_q;
  logic                       miso_q;

  //////////////////////////////////////////////////
  // pin synchronizers

  // cs_n idles high
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  // edges seen on the second flop, acted on one clk later
  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign cs_rise   = cs_sync[1] & ~cs_sync[2];
  assign cs_active = ~cs_sync[1];

  //////////////////////////////////////////////////
  // bit count, address latch and commit

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt   <= '0;
      addr_q    <= '0;
      load_pend <= 1'b0;
      valid_q   <= 1'b0;
    end
    else
    begin
      valid_q   <= 1'b0;
      load_pend <= 1'b0;
      if (!cs_active)
      begin
        bit_cnt <= '0;
        // only a frame of exactly 40 bits is committed
        if (cs_rise && bit_cnt == FRAME_LEN)
          valid_q <= 1'b1;
      end
      else if (sck_rise)
      begin
        // saturate so that long frames never wrap back to 40
        if (bit_cnt != CNT_MAX)
          bit_cnt <= bit_cnt + 1'b1;
        // eighth bit completes the address byte
        if (bit_cnt == ADDR_LEN - 1'b1)
        begin
          addr_q    <= {rx_shift[`SPI_ADDR_BITS-2:0], mosi_sync[1]};
          load_pend <= 1'b1;
        end
      end
    end
  end

  // receive shifter, MSB first
  always_ff @(posedge clk)
  begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[`SPI_FRAME_BITS-2:0], mosi_sync[1]};
  end

  //////////////////////////////////////////////////
  // read data path

  // rdata follows addr_q one clk after the address byte
  always_ff @(posedge clk)
  begin
    if (load_pend)
      tx_shift <= rdata;
    else if (sck_fall && bit_cnt >= ADDR_LEN && bit_cnt < FRAME_LEN)
      tx_shift <= {tx_shift[`SPI_DATA_BITS-2:0], 1'b0};
  end

  // miso changes after falling sck, ready for the next rise
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      miso_q <= 1'b0;
    else if (!cs_active)
      miso_q <= 1'b0;
    else if (sck_fall && bit_cnt >= ADDR_LEN && bit_cnt < FRAME_LEN)
      miso_q <= tx_shift[`SPI_DATA_BITS-1];
  end

  assign miso = miso_q;

  // data word sits in the low 32 bits once the frame is complete
  always_comb
  begin
    req.valid = valid_q;
    req.write = addr_q.write;
    req.index = addr_q.index;
    req.wdata = rx_shift[`SPI_DATA_BITS-1:0];
  end

endmodule

`default_nettype wire

/* register_bank.sv */
/*
  MCU register bank.
  LED, mode, direct and sample-duration registers, written and read over SPI.
*/

`timescale 1ns/100ps

`include "dmm_settings.svh"

`default_nettype none

module register_bank
  import spi_reg_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  reg_req_t                  req,
  output logic [`SPI_DATA_BITS-1:0] rdata,
  output reg_file_t                 regs
);

  //////////////////////////////////////////////////
  // write side

  // one clk after the request pulse
  // read frames arrive with write low and leave everything alone
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      regs <= '0;
    end
    else if (req.valid && req.write)
    begin
      case (req.index)
        `REG_LED:
          regs.led <= req.wdata;
        `REG_MODE:
          regs.mode <= req.wdata;
        `REG_DIRECT:
          regs.direct <= req.wdata;
        `REG_SAMPLE_DUR:
          regs.sample_dur <= req.wdata;
        default:
          regs <= regs;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read side

  // combinational on the latest address byte
  // the slave loads it into its shifter after bit eight
  always_comb
  begin
    rdata = '0;
    case (req.index)
      `REG_LED:
        rdata = regs.led;
      `REG_MODE:
        rdata = regs.mode;
      `REG_DIRECT:
        rdata = regs.direct;
      `REG_SAMPLE_DUR:
        rdata = regs.sample_dur;
      default:
        rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* modulation_az.sv */
/*
  Auto-zero sequencer.
  Alternates the az mux between the hi input and the lo code from direct,
  with the pre-charge switch closed during the hi phase.
*/

`timescale 1ns/100ps

`include "dmm_settings.svh"

`default_nettype none

module modulation_az
  import cond_pkg::*;
  import spi_reg_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  reg_file_t regs,
  output cond_word_u az_out
);

  logic                      run;
  logic                      phase_end;
  logic [`SPI_DATA_BITS-1:0] clk_cnt;
  // high during the hi phase
  logic                      hi_q;
  logic                      led_q;
  cond_word_u                direct_w;

  // lo code comes from the azmux field of direct
  assign direct_w.raw = regs.direct[`COND_BITS-1:0];

  // zero duration would never end a phase, so treat it as stopped
  assign run = (regs.mode[2:0] == `MODE_AZ) && (regs.sample_dur != '0);

  // >= so that shrinking the duration mid-phase cannot run the count away
  assign phase_end = (clk_cnt >= regs.sample_dur - 1'b1);

  //////////////////////////////////////////////////
  // phase sequencer

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      clk_cnt <= '0;
      hi_q    <= 1'b0;
      led_q   <= 1'b0;
    end
    else if (!run)
    begin
      // parked in phase 0, led keeps its last state
      clk_cnt <= '0;
      hi_q    <= 1'b0;
    end
    else if (phase_end)
    begin
      clk_cnt <= '0;
      hi_q    <= ~hi_q;
      // led blinks once per hi/lo pair, on entering hi
      if (!hi_q)
        led_q <= ~led_q;
    end
    else
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // output fields

  // only azmux, sig_pc_sw, led0 and monitor carry meaning here
  always_comb
  begin
    az_out                  = '0;
    az_out.fields.azmux     = hi_q ? mux4_t'(`AZMUX_HI_VAL) : direct_w.fields.azmux;
    az_out.fields.sig_pc_sw = hi_q;
    az_out.fields.led0      = led_q;
    // mon0 shows the phase, mon1 the led
    az_out.fields.monitor   = {6'b0, led_q, hi_q};
  end

endmodule

`default_nettype wire

/* conditioning_select.sv */
/*
  Mode mux for the conditioning output.
  Runs the test-pattern counter and registers the word picked by the mode register.
*/

`timescale 1ns/100ps

`include "dmm_settings.svh"

`default_nettype none

module conditioning_select
  import cond_pkg::*;
  import spi_reg_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  reg_file_t  regs,
  input  cond_word_u az_out,
  output cond_word_u cond
);

  logic [`COND_BITS-1:0] pattern_q;
  cond_word_u            direct_w;
  cond_word_u            next_w;

  assign direct_w.raw = regs.direct[`COND_BITS-1:0];

  // free-running test pattern, every output toggles at its own rate
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      pattern_q <= '0;
    else
      pattern_q <= pattern_q + 1'b1;
  end

  //////////////////////////////////////////////////
  // mode mux

  always_comb
  begin
    next_w.raw = '0;
    case (regs.mode[2:0])
      // mcu in control, everything off but the led
      `MODE_IDLE:
        next_w.fields.led0 = regs.led[0];
      `MODE_ONES:
        next_w.raw = '1;
      `MODE_PATTERN:
        next_w.raw = pattern_q;
      `MODE_DIRECT:
        next_w.raw = direct_w.raw;
      `MODE_AZ:
      begin
        next_w = az_out;
        // the hi muxes and adc lines stay under mcu control
        next_w.fields.himux         = direct_w.fields.himux;
        next_w.fields.himux2        = direct_w.fields.himux2;
        next_w.fields.adcmux        = direct_w.fields.adcmux;
        next_w.fields.cmpr_latch    = direct_w.fields.cmpr_latch;
        next_w.fields.meas_complete = direct_w.fields.meas_complete;
        next_w.fields.spi_interrupt = direct_w.fields.spi_interrupt;
      end
      // unused codes, all outputs off
      default:
        next_w.raw = '0;
    endcase
  end

  // registered so the pins switch together
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      cond <= '0;
    else
      cond <= next_w;
  end

endmodule

`default_nettype wire

/* dmm_fpga_top.sv */
/*
  Control FPGA top level for the multimeter front end.
  SPI register bank, auto-zero sequencer and mode mux.
*/

`timescale 1ns/100ps

`include "dmm_settings.svh"

`default_nettype none

module dmm_fpga_top
  import cond_pkg::*;
  import spi_reg_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       spi_sck,
  input  logic       spi_cs_n,
  input  logic       spi_mosi,
  output logic       spi_miso,
  output cond_word_u cond
);

  reg_req_t                  req;
  logic [`SPI_DATA_BITS-1:0] rdata;
  reg_file_t                 regs;
  cond_word_u                az_out;

  //////////////////////////////////////////////////
  // mcu access

  spi_slave u_spi_slave (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (spi_sck),
    .cs_n   (spi_cs_n),
    .mosi   (spi_mosi),
    .rdata  (rdata),
    .miso   (spi_miso),
    .req    (req)
  );

  register_bank u_register_bank (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .rdata  (rdata),
    .regs   (regs)
  );

  //////////////////////////////////////////////////
  // conditioning

  modulation_az u_modulation_az (
    .clk    (clk),
    .arst_n (arst_n),
    .regs   (regs),
    .az_out (az_out)
  );

  conditioning_select u_conditioning_select (
    .clk    (clk),
    .arst_n (arst_n),
    .regs   (regs),
    .az_out (az_out),
    .cond   (cond)
  );

endmodule

`default_nettype wire

/* dmm_fpga_sva.sv */
/*
  Assertions on the conditioning mode mux.
  Bound into every conditioning_select instance.
*/

`timescale 1ns/100ps

`include "dmm_settings.svh"

`default_nettype none

module dmm_fpga_sva
  import cond_pkg::*;
  import spi_reg_pkg::*;
(
  input logic       clk,
  input logic       arst_n,
  input reg_file_t  regs,
  input cond_word_u cond
);

  // count of failed assertions
  int fail_cnt = 0;

  // output register held clear while in reset
  a_reset_zero: assert property (@(posedge clk) !arst_n |-> cond.raw == '0)
    else
    begin
      fail_cnt++;
      $error("cond is not zero during reset");
    end

  // ones mode drives every line high one clk later
  a_ones: assert property (@(posedge clk) disable iff (!arst_n)
    regs.mode[2:0] == `MODE_ONES |=> cond.raw == '1)
    else
    begin
      fail_cnt++;
      $error("cond is not all ones in ones mode");
    end

  // two clk in pattern mode, counter steps by one
  a_pattern: assert property (@(posedge clk) disable iff (!arst_n)
    (regs.mode[2:0] == `MODE_PATTERN) ##1 (regs.mode[2:0] == `MODE_PATTERN)
    |=> cond.raw == $past(cond.raw) + 1'b1)
    else
    begin
      fail_cnt++;
      $error("test pattern did not increment by one");
    end

endmodule

bind conditioning_select dmm_fpga_sva u_dmm_fpga_sva (
  .clk    (clk),
  .arst_n (arst_n),
  .regs   (regs),
  .cond   (cond)
);

`default_nettype wire

/* tb_dmm_fpga.sv */
/*
  Testbench for the multimeter control FPGA.
  Plays SPI frames from the stimulus file, then checks pattern, direct and az modes.
*/

`timescale 1ns/100ps

`include "dmm_settings.svh"

`default_nettype none

module tb_dmm_fpga
  import cond_pkg::*;
();

  localparam int DRIVE_DLY = 10;
  // clk per sck half period
  localparam int HALF_SCK = 4;
  localparam int SETTLE = 8;
  localparam int AZ_LEN = 6;
  // lo code 0011, himux 1101, adcmux 0110
  localparam logic [31:0] AZ_DIRECT = 32'h018000d3;

  logic        clk;
  logic        arst_n;
  logic        spi_sck;
  logic        spi_cs_n;
  logic        spi_mosi;
  logic        spi_miso;
  cond_word_u  cond;
  int          err_cnt;
  int          check_cnt;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] model [0:3];
  logic [31:0] rnd;

  dmm_fpga_top UUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .spi_sck  (spi_sck),
    .spi_cs_n (spi_cs_n),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .cond     (cond)
  );

  always #50 clk = ~clk;

  // watchdog, limit sized from the stimulus length
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // land a small delay after the rising edge
  task automatic step_clocks(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    err_cnt++;
  endtask

  //////////////////////////////////////////////////
  // spi mode 0 master

  // mosi set with sck low, miso taken as sck rises
  task automatic spi_transfer(input logic [7:0] addr, input logic [31:0] wdata,
                              input int nbits, output logic [31:0] rdata);
    logic [39:0] frame;
    int          i;
    frame    = {addr, wdata};
    rdata    = '0;
    spi_cs_n = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      spi_sck  = 1'b0;
      spi_mosi = frame[39 - i];
      step_clocks(HALF_SCK);
      spi_sck = 1'b1;
      if (i >= `SPI_ADDR_BITS)
        rdata = {rdata[30:0], spi_miso};
      step_clocks(HALF_SCK);
    end
    spi_sck = 1'b0;
    step_clocks(HALF_SCK);
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    step_clocks(HALF_SCK);
  endtask

  task automatic spi_write(input logic [1:0] idx, input logic [31:0] data);
    logic [31:0] rd;
    spi_transfer({1'b1, 5'b0, idx}, data, `SPI_FRAME_BITS, rd);
    model[idx] = data;
  endtask

  task automatic spi_read(input logic [1:0] idx, output logic [31:0] data);
    spi_transfer({1'b0, 5'b0, idx}, 32'h0, `SPI_FRAME_BITS, data);
  endtask

  task automatic check_cond(input logic [28:0] exp);
    step_clocks(SETTLE);
    check_cnt++;
    if (cond.raw !== exp)
      report_mismatch("cond", {3'b0, cond.raw}, {3'b0, exp});
  endtask

  //////////////////////////////////////////////////
  // directed checks after the file

  // cut off after 20 bits, the led register must keep its value
  task automatic short_frame_check();
    logic [31:0] rd;
    spi_transfer({1'b1, 5'b0, `REG_LED}, 32'hdeadbeef, 20, rd);
    spi_read(`REG_LED, rd);
    check_cnt++;
    if (rd !== model[`REG_LED])
      report_mismatch("led after short frame", rd, model[`REG_LED]);
  endtask

  // direct mode passes the low 29 bits through
  task automatic random_direct_check();
    int k;
    spi_write(`REG_MODE, 32'd3);
    for (k = 0; k < 3; k++)
    begin
      rnd = xorshift32(rnd);
      spi_write(`REG_DIRECT, rnd);
      check_cond(rnd[28:0]);
    end
  endtask

  task automatic pattern_check();
    logic [28:0] prev;
    logic [28:0] nxt;
    int          k;
    spi_write(`REG_MODE, 32'd2);
    step_clocks(SETTLE);
    prev = cond.raw;
    for (k = 0; k < 16; k++)
    begin
      step_clocks(1);
      nxt = prev + 1'b1;
      check_cnt++;
      if (cond.raw !== nxt)
        report_mismatch("pattern", {3'b0, cond.raw}, {3'b0, nxt});
      prev = cond.raw;
    end
  endtask

  task automatic az_check();
    logic       prev_sig;
    logic       last_hi_led;
    logic [3:0] exp_az;
    int         run_len;
    int         phases;
    int         guard;
    spi_write(`REG_DIRECT, AZ_DIRECT);
    spi_write(`REG_SAMPLE_DUR, AZ_LEN);
    spi_write(`REG_MODE, 32'd4);
    step_clocks(SETTLE);
    // align to a lo to hi change of the pre-charge switch
    guard = 0;
    do
    begin
      prev_sig = cond.fields.sig_pc_sw;
      step_clocks(1);
      guard++;
    end
    while ((prev_sig || !cond.fields.sig_pc_sw) && guard < 4 * AZ_LEN);
    if (prev_sig || !cond.fields.sig_pc_sw)
    begin
      $display("az sequencer never entered a hi phase");
      err_cnt++;
    end
    last_hi_led = cond.fields.led0;
    prev_sig    = 1'b1;
    run_len     = 0;
    phases      = 0;
    while (phases < 6)
    begin
      if (cond.fields.sig_pc_sw != prev_sig)
      begin
        check_cnt++;
        if (run_len != AZ_LEN)
          report_mismatch("az phase length", run_len, AZ_LEN);
        phases++;
        run_len  = 0;
        prev_sig = cond.fields.sig_pc_sw;
        // led flips on every new hi phase
        if (prev_sig)
        begin
          check_cnt++;
          if (cond.fields.led0 !== ~last_hi_led)
            report_mismatch("led0 at hi phase", {31'b0, cond.fields.led0},
                            {31'b0, ~last_hi_led});
          last_hi_led = cond.fields.led0;
        end
      end
      exp_az = prev_sig ? `AZMUX_HI_VAL : AZ_DIRECT[3:0];
      check_cnt++;
      if (cond.fields.azmux !== exp_az)
        report_mismatch("azmux", {28'b0, cond.fields.azmux}, {28'b0, exp_az});
      if (cond.fields.himux !== AZ_DIRECT[7:4])
        report_mismatch("himux", {28'b0, cond.fields.himux}, {28'b0, AZ_DIRECT[7:4]});
      if (cond.fields.adcmux !== AZ_DIRECT[25:22])
        report_mismatch("adcmux", {28'b0, cond.fields.adcmux}, {28'b0, AZ_DIRECT[25:22]});
      // mon0 is the phase, mon1 the led
      if (cond.fields.monitor !== {6'b0, last_hi_led, prev_sig})
        report_mismatch("monitor", {24'b0, cond.fields.monitor},
                        {24'b0, 6'b0, last_hi_led, prev_sig});
      run_len++;
      step_clocks(1);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    int                fd;
    int                n;
    int                n_lines;
    int                sva_fails;
    logic [7:0]        op;
    logic [31:0]       f1;
    logic [31:0]       f2;
    logic [31:0]       rd;
    logic [8*128-1:0]  text;
    clk       = 1'b0;
    arst_n    = 1'b0;
    spi_sck   = 1'b0;
    spi_cs_n  = 1'b1;
    spi_mosi  = 1'b0;
    err_cnt   = 0;
    check_cnt = 0;
    cycle_cnt = 0;
    rnd       = 32'h36a0;
    for (n = 0; n < 4; n++)
      model[n] = '0;
    fd = $fopen("dmm_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open stimulus file dmm_stimulus.txt");
      $display("TESTS FAILED");
      $finish;
    end
    else
    begin
      n_lines = 0;
      while ($fgets(text, fd) != 0)
        n_lines++;
      $fclose(fd);
      cycle_limit = n_lines * 400 + 2000;
      step_clocks(8);
      arst_n = 1'b1;
      fd = $fopen("dmm_stimulus.txt", "r");
      while ($fscanf(fd, "%s", op) == 1)
      begin
        case (op)
          "#":
            n = $fgets(text, fd);
          "W":
          begin
            n = $fscanf(fd, "%h %h", f1, f2);
            spi_write(f1[1:0], f2);
          end
          "R":
          begin
            n = $fscanf(fd, "%h %h", f1, f2);
            spi_read(f1[1:0], rd);
            check_cnt++;
            if (rd !== f2)
              report_mismatch("register read", rd, f2);
          end
          "C":
          begin
            n = $fscanf(fd, "%h", f1);
            check_cond(f1[28:0]);
          end
          default:
          begin
            $display("unknown operation in stimulus file");
            err_cnt++;
          end
        endcase
      end
      $fclose(fd);
      short_frame_check();
      random_direct_check();
      pattern_check();
      az_check();
      sva_fails = UUT.u_conditioning_select.u_dmm_fpga_sva.fail_cnt;
      err_cnt   = err_cnt + sva_fails;
      $display("checks run: %0d, errors: %0d, assertion failures: %0d",
               check_cnt, err_cnt, sva_fails);
      if (err_cnt == 0)
        $display("TESTS PASSED");
      else
        $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
cond_pkg.sv
spi_reg_pkg.sv
spi_slave.sv
register_bank.sv
modulation_az.sv
conditioning_select.sv
dmm_fpga_top.sv
dmm_fpga_sva.sv
tb_dmm_fpga.sv

/* Bender.yml */
package:
  name: dmm_fpga

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cond_pkg.sv
      - spi_reg_pkg.sv
      - spi_slave.sv
      - register_bank.sv
      - modulation_az.sv
      - conditioning_select.sv
      - dmm_fpga_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dmm_fpga_sva.sv
      - tb_dmm_fpga.sv

/* dmm_stimulus.txt */
# op index data : W writes data to a register, R reads it and expects data
# op C expected : conditioning word checked once the output has settled
C 00000000
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
W 0 a5a5a5a5
W 2 12345678
W 3 0000beef
R 0 a5a5a5a5
R 2 12345678
R 3 0000beef
W 0 00000001
W 1 00000000
C 00002000
W 1 00000001
C 1fffffff
W 1 00000003
C 12345678
W 2 fedcba98
C 1edcba98
W 1 00000006
C 00000000
R 1 00000006
